//--- rtl/cache_pkg.sv
package cache_pkg;

   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;
   localparam int ADDR_W = 12; // Word address, so the space is 4K words.

   // Front-end request. A request with no strobes set is a read.
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } cache_req_t;

   // Back-end access, also the entry format of the write-through buffer.
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } be_req_t;

   // Replaces the bytes of old_word selected by strb with those of new_word.
   function automatic logic [DATA_W-1:0] merge_bytes(
      input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word,
      input logic [NBYTES-1:0] strb
   );
      logic [DATA_W-1:0] merged;
      merged = old_word;
      for (int b = 0; b < NBYTES; b++) begin
         if (strb[b]) begin
            merged[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return merged;
   endfunction

endpackage

//--- rtl/cache_memory.sv
`timescale 1ns/1ps

module cache_memory #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [cache_pkg::ADDR_W-1:0]      lookup_addr,
   input  logic                              word_we,
   input  logic [cache_pkg::DATA_W-1:0]      word_wdata,
   input  logic [cache_pkg::NBYTES-1:0]      word_wstrb,
   input  logic                              fill_we,
   input  logic [WORD_OFFSET_W-1:0]          fill_offset,
   input  logic [cache_pkg::DATA_W-1:0]      fill_data,
   input  logic                              fill_done,
   input  logic                              invalidate,
   output logic                              hit,
   output logic [cache_pkg::DATA_W-1:0]      rdata
);

   localparam int NLINES = 2 ** NLINES_W;
   localparam int NWORDS = 2 ** WORD_OFFSET_W;
   localparam int TAG_W  = cache_pkg::ADDR_W - NLINES_W - WORD_OFFSET_W;

   logic [cache_pkg::DATA_W-1:0] data_mem [NLINES*NWORDS];
   logic [TAG_W-1:0]             tag_mem  [NLINES];
   logic [NLINES-1:0]            valid;

   logic [TAG_W-1:0]             addr_tag;
   logic [NLINES_W-1:0]          line_index;
   logic [WORD_OFFSET_W-1:0]     word_offset;
   logic [cache_pkg::DATA_W-1:0] merged_word;

   assign addr_tag    = lookup_addr[cache_pkg::ADDR_W-1 -: TAG_W];
   assign line_index  = lookup_addr[WORD_OFFSET_W +: NLINES_W];
   assign word_offset = lookup_addr[WORD_OFFSET_W-1:0];

   assign hit   = valid[line_index] && (tag_mem[line_index] == addr_tag);
   assign rdata = data_mem[{line_index, word_offset}];

   assign merged_word = cache_pkg::merge_bytes(rdata, word_wdata, word_wstrb);

   // A write miss leaves the line alone since there is no write allocate.
   always_ff @(posedge clk) begin
      if (fill_we) begin
         data_mem[{line_index, fill_offset}] <= fill_data;
      end else if (word_we && hit) begin
         data_mem[{line_index, word_offset}] <= merged_word;
      end
      if (fill_done) begin
         tag_mem[line_index] <= addr_tag;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid <= '0;
      end else if (invalidate) begin
         valid <= '0;
      end else if (fill_done) begin
         valid[line_index] <= 1'b1; // The last fill word lands on this same edge.
      end
   end

endmodule

//--- rtl/write_through_buffer.sv
`timescale 1ns/1ps

module write_through_buffer #(
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                push,
   input  cache_pkg::be_req_t  push_data,
   input  logic                pop,
   output cache_pkg::be_req_t  head,
   output logic                full,
   output logic                empty
);

   localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

   cache_pkg::be_req_t       entries [DEPTH];
   logic [WTBUF_DEPTH_W-1:0] wr_ptr;
   logic [WTBUF_DEPTH_W-1:0] rd_ptr;
   logic [WTBUF_DEPTH_W:0]   count;
   logic                     do_push;
   logic                     do_pop;

   assign full  = (count == DEPTH[WTBUF_DEPTH_W:0]);
   assign empty = (count == '0);
   assign head  = entries[rd_ptr];

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk) begin
      if (do_push) begin
         entries[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the power-of-two depth.
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- rtl/cache_control.sv
`timescale 1ns/1ps

module cache_control #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          req,
   input  cache_pkg::cache_req_t         req_data,
   input  logic                          invalidate,
   output logic                          ack,
   output logic [cache_pkg::DATA_W-1:0]  rdata,
   input  logic                          hit,
   input  logic [cache_pkg::DATA_W-1:0]  mem_rdata,
   output logic [cache_pkg::ADDR_W-1:0]  lookup_addr,
   output logic                          word_we,
   output logic [cache_pkg::DATA_W-1:0]  word_wdata,
   output logic [cache_pkg::NBYTES-1:0]  word_wstrb,
   output logic                          fill_we,
   output logic [WORD_OFFSET_W-1:0]      fill_offset,
   output logic [cache_pkg::DATA_W-1:0]  fill_data,
   output logic                          fill_done,
   output logic                          mem_invalidate,
   input  cache_pkg::be_req_t            wtb_head,
   input  logic                          wtb_full,
   input  logic                          wtb_empty,
   output logic                          wtb_push,
   output cache_pkg::be_req_t            wtb_push_data,
   output logic                          wtb_pop,
   input  logic                          be_ack,
   input  logic [cache_pkg::DATA_W-1:0]  be_rdata,
   output logic                          be_req,
   output cache_pkg::be_req_t            be_data
);

   typedef enum logic [1:0] {
      st_idle,
      st_wait_drain,
      st_fill,
      st_respond
   } state_t;

   state_t                       state;
   logic [cache_pkg::ADDR_W-1:0] req_addr;
   logic [WORD_OFFSET_W-1:0]     fill_cnt;
   logic                         be_busy;
   logic                         be_kind_fill;

   logic                         is_write;
   logic                         new_req;
   logic                         accept_write;
   logic                         read_hit;
   logic                         read_miss;
   logic                         fill_ack;
   logic                         fill_last;
   logic                         issue_fill;
   logic                         issue_drain;
   cache_pkg::be_req_t           fill_access;

   assign is_write = |req_data.wstrb;

   // The request is still held high during the ack cycle and must not start again.
   assign new_req      = req && !ack && (state == st_idle);
   assign accept_write = new_req && is_write && !wtb_full;
   assign read_hit     = new_req && !is_write && hit;
   assign read_miss    = new_req && !is_write && !hit;

   assign lookup_addr = (state == st_idle) ? req_data.addr : req_addr;

   assign word_we    = accept_write;
   assign word_wdata = req_data.wdata;
   assign word_wstrb = req_data.wstrb;

   assign wtb_push            = accept_write;
   assign wtb_push_data.addr  = req_data.addr;
   assign wtb_push_data.wdata = req_data.wdata;
   assign wtb_push_data.wstrb = req_data.wstrb;

   assign fill_ack    = be_ack && be_kind_fill;
   assign fill_last   = &fill_cnt;
   assign fill_we     = fill_ack;
   assign fill_offset = fill_cnt;
   assign fill_data   = be_rdata;
   assign fill_done   = fill_ack && fill_last;

   assign wtb_pop = be_ack && !be_kind_fill; // Head leaves once RAM has taken it.

   assign mem_invalidate = invalidate && (state == st_idle) && !req;

   // One access in flight at a time, fills take the port whenever filling.
   assign issue_fill  = (state == st_fill) && !be_busy;
   assign issue_drain = (state != st_fill) && !be_busy && !wtb_empty;

   assign fill_access.addr  = {req_addr[cache_pkg::ADDR_W-1:WORD_OFFSET_W], fill_cnt};
   assign fill_access.wdata = '0;
   assign fill_access.wstrb = '0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state        <= st_idle;
         ack          <= 1'b0;
         be_req       <= 1'b0;
         be_busy      <= 1'b0;
         be_kind_fill <= 1'b0;
         fill_cnt     <= '0;
      end else begin
         ack    <= 1'b0;
         be_req <= issue_fill || issue_drain;
         if (issue_fill || issue_drain) begin
            be_busy      <= 1'b1;
            be_kind_fill <= issue_fill;
         end else if (be_ack) begin
            be_busy <= 1'b0;
         end
         if (fill_ack) begin
            fill_cnt <= fill_cnt + 1'b1;
         end
         case (state)
            st_idle: begin
               if (accept_write || read_hit) begin
                  ack <= 1'b1;
               end else if (read_miss) begin
                  state <= st_wait_drain;
               end
            end
            st_wait_drain: begin
               if (wtb_empty && !be_busy) begin // Keeps reads behind older writes.
                  state    <= st_fill;
                  fill_cnt <= '0;
               end
            end
            st_fill: begin
               if (fill_done) begin
                  state <= st_respond;
               end
            end
            default: begin
               ack   <= 1'b1;
               state <= st_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (read_hit || (state == st_respond)) begin
         rdata <= mem_rdata;
      end
      if (read_miss) begin
         req_addr <= req_data.addr;
      end
      if (issue_fill) begin
         be_data <= fill_access;
      end else if (issue_drain) begin
         be_data <= wtb_head;
      end
   end

endmodule

//--- rtl/backing_ram.sv
`timescale 1ns/1ps

module backing_ram #(
   parameter int DEPTH_W = 12
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          be_req,
   input  cache_pkg::be_req_t            be_data,
   output logic                          be_ack,
   output logic [cache_pkg::DATA_W-1:0]  be_rdata
);

   localparam int DEPTH = 2 ** DEPTH_W;

   logic [cache_pkg::DATA_W-1:0] ram [DEPTH];
   logic [DEPTH_W-1:0]           word_addr;
   logic [cache_pkg::DATA_W-1:0] merged_word;

   assign word_addr   = be_data.addr[DEPTH_W-1:0];
   assign merged_word = cache_pkg::merge_bytes(ram[word_addr], be_data.wdata, be_data.wstrb);

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         ram[i] = '0;
      end
   end

   // Read data is the old word, which only matters for accesses without strobes.
   always @(posedge clk) begin
      if (be_req) begin
         be_rdata <= ram[word_addr];
         if (|be_data.wstrb) begin
            ram[word_addr] <= merged_word;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         be_ack <= 1'b0;
      end else begin
         be_ack <= be_req;
      end
   end

endmodule

//--- rtl/cache_sim_wrapper.sv
`timescale 1ns/1ps

module cache_sim_wrapper #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2,
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          req,
   input  cache_pkg::cache_req_t         req_data,
   input  logic                          invalidate,
   output logic                          ack,
   output logic [cache_pkg::DATA_W-1:0]  rdata,
   output logic                          wtb_empty
);

   logic [cache_pkg::ADDR_W-1:0] lookup_addr;
   logic                         hit;
   logic [cache_pkg::DATA_W-1:0] mem_rdata;
   logic                         word_we;
   logic [cache_pkg::DATA_W-1:0] word_wdata;
   logic [cache_pkg::NBYTES-1:0] word_wstrb;
   logic                         fill_we;
   logic [WORD_OFFSET_W-1:0]     fill_offset;
   logic [cache_pkg::DATA_W-1:0] fill_data;
   logic                         fill_done;
   logic                         mem_invalidate;

   cache_pkg::be_req_t           wtb_head;
   cache_pkg::be_req_t           wtb_push_data;
   logic                         wtb_full;
   logic                         wtb_push;
   logic                         wtb_pop;

   logic                         be_req;
   cache_pkg::be_req_t           be_data;
   logic                         be_ack;
   logic [cache_pkg::DATA_W-1:0] be_rdata;

   cache_control #(
      .NLINES_W      (NLINES_W),
      .WORD_OFFSET_W (WORD_OFFSET_W)
   ) control_i (
      .clk            (clk),
      .rst            (rst),
      .req            (req),
      .req_data       (req_data),
      .invalidate     (invalidate),
      .ack            (ack),
      .rdata          (rdata),
      .hit            (hit),
      .mem_rdata      (mem_rdata),
      .lookup_addr    (lookup_addr),
      .word_we        (word_we),
      .word_wdata     (word_wdata),
      .word_wstrb     (word_wstrb),
      .fill_we        (fill_we),
      .fill_offset    (fill_offset),
      .fill_data      (fill_data),
      .fill_done      (fill_done),
      .mem_invalidate (mem_invalidate),
      .wtb_head       (wtb_head),
      .wtb_full       (wtb_full),
      .wtb_empty      (wtb_empty),
      .wtb_push       (wtb_push),
      .wtb_push_data  (wtb_push_data),
      .wtb_pop        (wtb_pop),
      .be_ack         (be_ack),
      .be_rdata       (be_rdata),
      .be_req         (be_req),
      .be_data        (be_data)
   );

   cache_memory #(
      .NLINES_W      (NLINES_W),
      .WORD_OFFSET_W (WORD_OFFSET_W)
   ) memory_i (
      .clk         (clk),
      .rst         (rst),
      .lookup_addr (lookup_addr),
      .word_we     (word_we),
      .word_wdata  (word_wdata),
      .word_wstrb  (word_wstrb),
      .fill_we     (fill_we),
      .fill_offset (fill_offset),
      .fill_data   (fill_data),
      .fill_done   (fill_done),
      .invalidate  (mem_invalidate),
      .hit         (hit),
      .rdata       (mem_rdata)
   );

   write_through_buffer #(
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) wtbuf_i (
      .clk       (clk),
      .rst       (rst),
      .push      (wtb_push),
      .push_data (wtb_push_data),
      .pop       (wtb_pop),
      .head      (wtb_head),
      .full      (wtb_full),
      .empty     (wtb_empty)
   );

   backing_ram #(
      .DEPTH_W (cache_pkg::ADDR_W)
   ) ram_i (
      .clk      (clk),
      .rst      (rst),
      .be_req   (be_req),
      .be_data  (be_data),
      .be_ack   (be_ack),
      .be_rdata (be_rdata)
   );

endmodule

//--- sim/cache_tb_model.svh
`ifndef CACHE_TB_MODEL_SVH
`define CACHE_TB_MODEL_SVH

typedef enum {lat_any, lat_one, lat_multi} latency_t;

logic [cache_pkg::DATA_W-1:0] shadow [2**cache_pkg::ADDR_W];
logic                         check_read;
logic [cache_pkg::DATA_W-1:0] exp_rdata;
latency_t                     exp_latency;

function automatic void shadow_write(
   input logic [cache_pkg::ADDR_W-1:0] addr,
   input logic [cache_pkg::DATA_W-1:0] data,
   input logic [cache_pkg::NBYTES-1:0] strb
);
   for (int b = 0; b < cache_pkg::NBYTES; b++) begin
      if (strb[b]) begin
         shadow[addr][8*b +: 8] = data[8*b +: 8];
      end
   end
endfunction

// Each request starts one edge after the previous ack, so req is low for one sample in between.
task automatic run_request(
   input logic [cache_pkg::ADDR_W-1:0] addr,
   input logic [cache_pkg::DATA_W-1:0] data,
   input logic [cache_pkg::NBYTES-1:0] strb,
   input latency_t                     latency
);
   @(posedge clk);
   #1;
   req            = 1'b1;
   req_data.addr  = addr;
   req_data.wdata = data;
   req_data.wstrb = strb;
   check_read     = (strb == '0);
   exp_rdata      = shadow[addr];
   exp_latency    = latency;
   do begin
      @(posedge clk);
      #1;
   end while (!ack);
   req = 1'b0;
   shadow_write(addr, data, strb);
endtask

task automatic wait_drain();
   while (!wtb_empty) begin
      @(posedge clk);
      #1;
   end
endtask

task automatic pulse_invalidate();
   @(posedge clk);
   #1;
   invalidate = 1'b1;
   @(posedge clk);
   #1;
   invalidate = 1'b0;
endtask

`endif

//--- sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

   localparam int CYCLE_LIMIT = 20000; // About 600 requests at up to 30 cycles each.

   logic                         clk;
   logic                         rst;
   logic                         req;
   cache_pkg::cache_req_t        req_data;
   logic                         invalidate;
   logic                         ack;
   logic [cache_pkg::DATA_W-1:0] rdata;
   logic                         wtb_empty;
   int                           cycle_count;
   integer                       seed;

   `include "cache_tb_model.svh"

   cache_sim_wrapper #(
      .NLINES_W      (4),
      .WORD_OFFSET_W (2),
      .WTBUF_DEPTH_W (2)
   ) cache_sim_wrapper_i (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .req_data   (req_data),
      .invalidate (invalidate),
      .ack        (ack),
      .rdata      (rdata),
      .wtb_empty  (wtb_empty)
   );

   task automatic abort_run();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic value_error(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      abort_run();
   endtask

   ack_after_reset: assert property (@(posedge clk) $fell(rst) |-> !ack)
      else value_error("ack", 32'd0, $sampled(ack));
   empty_after_reset: assert property (@(posedge clk) $fell(rst) |-> wtb_empty)
      else value_error("wtb_empty", 32'd1, $sampled(wtb_empty));
   read_data: assert property (@(posedge clk) disable iff (rst)
         (ack && check_read) |-> (rdata == exp_rdata))
      else value_error("rdata", $sampled(exp_rdata), $sampled(rdata));
   one_cycle_ack: assert property (@(posedge clk) disable iff (rst)
         ($rose(req) && exp_latency == lat_one) |=> ack)
      else value_error("ack", 32'd1, $sampled(ack));
   multi_cycle_ack: assert property (@(posedge clk) disable iff (rst)
         ($rose(req) && exp_latency == lat_multi) |=> !ack)
      else value_error("ack", 32'd0, $sampled(ack));

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d clock cycles, a request or a drain never finished.", CYCLE_LIMIT);
      abort_run();
   end

   initial begin
      logic [cache_pkg::ADDR_W-1:0] addr;
      logic [cache_pkg::DATA_W-1:0] data;
      logic [cache_pkg::NBYTES-1:0] strb;
      seed        = 40;
      rst         = 1'b1;
      req         = 1'b0;
      req_data    = '0;
      invalidate  = 1'b0;
      check_read  = 1'b0;
      exp_rdata   = '0;
      exp_latency = lat_any;
      foreach (shadow[i]) begin
         shadow[i] = '0;
      end
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < 8; i++) begin
         run_request(12'h100 + 12'(3 * i), '0, '0, lat_any);
      end
      run_request(12'h020, '0, '0, lat_any); // Words 0x20 to 0x23 hit, 0x24 to 0x27 miss.
      for (int i = 0; i < 16; i++) begin
         run_request(12'h020 + 12'(i % 8), 32'ha5c3_0f00 ^ (32'h0101_0101 * i), 4'(i + 1), lat_any);
      end
      for (int i = 0; i < 8; i++) begin
         run_request(12'h020 + 12'(i), '0, '0, lat_any);
      end
      run_request(12'h200, '0, '0, lat_any);
      run_request(12'h200, '0, '0, lat_one);
      run_request(12'h203, '0, '0, lat_one);
      wait_drain();
      run_request(12'h201, 32'hdead_beef, 4'b0110, lat_one);
      run_request(12'h201, '0, '0, lat_one);
      for (int i = 0; i < 10; i++) begin
         run_request(12'h300 + 12'(i), 32'h3000_0000 + 32'(i * 7), 4'hf, lat_any);
      end
      wait_drain();
      for (int i = 0; i < 10; i++) begin
         run_request(12'h300 + 12'(i), '0, '0, lat_any);
      end
      run_request(12'h200, '0, '0, lat_any);
      run_request(12'h201, '0, '0, lat_one);
      pulse_invalidate();
      run_request(12'h201, '0, '0, lat_multi); // Valid bits are gone, so this refills.
      run_request(12'h201, '0, '0, lat_one);
      for (int i = 0; i < 500; i++) begin
         addr = 12'h400 + 12'($random(seed) & 32'h7f);
         data = $random(seed);
         strb = ($random(seed) & 1) ? 4'($random(seed)) : 4'b0000;
         run_request(addr, data, strb, lat_any);
      end
      wait_drain();
      repeat (2) @(posedge clk);
      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- cache_sim_wrapper.f
+incdir+sim
rtl/cache_pkg.sv
rtl/cache_memory.sv
rtl/write_through_buffer.sv
rtl/cache_control.sv
rtl/backing_ram.sv
rtl/cache_sim_wrapper.sv
sim/cache_tb.sv
